//--- design/pipe_trace_top.sv
/* Pipeline trace unit top
   Control, capture, retire queue and Wishbone read port */
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  trace_pkg::stage_words_t obs,     // One word per stage each cycle
    input  logic                    stall,
    input  logic                    hlt,
    input  trace_pkg::wb_req_t      wb_req,
    output trace_pkg::wb_rsp_t      wb_rsp
);
    import trace_pkg::*;

    stage_ctl_t ctl;        // Per-stage ids and valids
    logic       ret_valid;
    trace_rec_t ret_rec;
    trace_rec_t head;       // Oldest queued record
    logic [2:0] count;
    logic [7:0] drops;
    logic       pop;

    trace_ctrl u_ctrl (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .hlt   (hlt),
        .ctl   (ctl)
    );

    trace_capture u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctl       (ctl),
        .obs       (obs),
        .ret_valid (ret_valid),
        .ret_rec   (ret_rec)
    );

    // Retired records enter the queue the cycle they appear
    trace_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .push     (ret_valid),
        .push_rec (ret_rec),
        .pop      (pop),
        .head     (head),
        .count    (count),
        .drops    (drops)
    );

    trace_wb_slave u_wb (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .head   (head),
        .count  (count),
        .drops  (drops),
        .pop    (pop)
    );

endmodule

//--- design/trace_capture.sv
/* Trace capture, stores each stage's word into the slot of the
   instruction it belongs to and emits the finished record at write-back */
`timescale 1ns/1ps

module trace_capture (
    input  logic                    clk,
    input  logic                    rst_n,
    input  trace_pkg::stage_ctl_t   ctl,
    input  trace_pkg::stage_words_t obs,
    output logic                    ret_valid,  // One cycle per retired record
    output trace_pkg::trace_rec_t   ret_rec
);
    import trace_pkg::*;

    // Slot storage, one field array per stage
    logic [WORD_W-1:0] fetch_mem [SLOT_NUM];
    logic [WORD_W-1:0] dec_mem   [SLOT_NUM];
    logic [WORD_W-1:0] exe_mem   [SLOT_NUM];
    logic [WORD_W-1:0] mem_mem   [SLOT_NUM];
    logic [7:0]        cnt_mem   [SLOT_NUM];   // Decode stall cycles

    logic [SLOT_W-1:0] f_slot, d_slot, e_slot, m_slot, w_slot;

    assign f_slot = ctl.f_id[SLOT_W-1:0];
    assign d_slot = ctl.d_id[SLOT_W-1:0];
    assign e_slot = ctl.e_id[SLOT_W-1:0];
    assign m_slot = ctl.m_id[SLOT_W-1:0];
    assign w_slot = ctl.w_id[SLOT_W-1:0];

    ////////////////////
    // Slot writes
    ////////////////////
    // Fetch and decode rewrite every stalled cycle, last value wins
    always_ff @(posedge clk) begin
        if (ctl.f_valid) begin
            fetch_mem[f_slot] <= obs.fetch;
            cnt_mem[f_slot]   <= '0;            // New instruction starts at zero
        end
        if (ctl.d_valid) dec_mem[d_slot] <= obs.decode;
        if (ctl.d_stall && (cnt_mem[d_slot] != 8'hFF)) begin
            cnt_mem[d_slot] <= cnt_mem[d_slot] + 1'b1;
        end
        if (ctl.e_valid) exe_mem[e_slot] <= obs.execute;
        if (ctl.m_valid) mem_mem[m_slot] <= obs.memory;
    end

    ////////////////////
    // Retire
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= ctl.w_valid;
        end
    end

    // Record payload, write-back word taken live
    always_ff @(posedge clk) begin
        if (ctl.w_valid) begin
            ret_rec.id            <= ctl.w_id;
            ret_rec.stall_cnt     <= cnt_mem[w_slot];
            ret_rec.words.fetch   <= fetch_mem[w_slot];
            ret_rec.words.decode  <= dec_mem[w_slot];
            ret_rec.words.execute <= exe_mem[w_slot];
            ret_rec.words.memory  <= mem_mem[w_slot];
            ret_rec.words.wb      <= obs.wb;
        end
    end

endmodule

//--- design/trace_ctrl.sv
/* Trace control, tags each fetched instruction with a sequence id
   and follows its id and valid through the five pipeline stages */
`timescale 1ns/1ps

module trace_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,   // Freezes fetch and decode
    input  logic                  hlt,     // Instruction in fetch is the last one
    output trace_pkg::stage_ctl_t ctl
);
    import trace_pkg::*;

    logic [ID_W-1:0] id_cnt;   // Next id to hand out
    logic            halted;   // Set once hlt is taken, cleared only by reset

    logic            f_valid, d_valid, e_valid, m_valid, w_valid;
    logic [ID_W-1:0] f_id, d_id, e_id, m_id, w_id;

    ////////////////////
    // Fetch
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_cnt  <= '0;
            halted  <= 1'b0;
            f_valid <= 1'b0;
            f_id    <= '0;
        end else if (!stall) begin
            if (halted || hlt) begin
                f_valid <= 1'b0;            // No new fetch once halt is seen
            end else begin
                f_valid <= 1'b1;
                f_id    <= id_cnt;          // Tag the new instruction
                id_cnt  <= id_cnt + 1'b1;
            end
            if (hlt) begin
                halted <= 1'b1;             // Pipeline drains from here
            end
        end
        // Stall: fetch holds id and valid
    end

    ////////////////////
    // Decode and execute
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
            d_id    <= '0;
            e_valid <= 1'b0;
            e_id    <= '0;
        end else if (stall) begin
            e_valid <= 1'b0;                // Bubble into execute, decode holds
        end else begin
            d_valid <= f_valid;
            d_id    <= f_id;
            e_valid <= d_valid;
            e_id    <= d_id;
        end
    end

    ////////////////////
    // Memory and write-back
    ////////////////////
    // Back end always advances, stall or not
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_valid <= 1'b0;
            m_id    <= '0;
            w_valid <= 1'b0;
            w_id    <= '0;
        end else begin
            m_valid <= e_valid;
            m_id    <= e_id;
            w_valid <= m_valid;
            w_id    <= m_id;
        end
    end

    // Pack the tracking state for the capture block
    always_comb begin
        ctl         = '0;
        ctl.f_valid = f_valid;
        ctl.f_id    = f_id;
        ctl.d_valid = d_valid;
        ctl.d_id    = d_id;
        ctl.d_stall = stall && d_valid;     // Counted against the decode instruction
        ctl.e_valid = e_valid;
        ctl.e_id    = e_id;
        ctl.m_valid = m_valid;
        ctl.m_id    = m_id;
        ctl.w_valid = w_valid;
        ctl.w_id    = w_id;
    end

endmodule

//--- design/trace_fifo.sv
/* Retired record queue, four entries deep
   Records arriving while full are dropped and counted */
`timescale 1ns/1ps

module trace_fifo (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  trace_pkg::trace_rec_t push_rec,
    input  logic                  pop,      // Ignored when empty
    output trace_pkg::trace_rec_t head,
    output logic [2:0]            count,
    output logic [7:0]            drops     // Saturates at 255
);
    import trace_pkg::*;

    trace_rec_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr, rd_ptr;
    logic               full, empty;
    logic               do_push, do_pop;

    assign full    = (count == 3'(FIFO_DEPTH));
    assign empty   = (count == 3'd0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign head    = mem[rd_ptr];           // Head is always visible to the bus

    ////////////////////
    // Storage
    ////////////////////
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_rec;
    end

    ////////////////////
    // Pointers and counters
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drops  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + {2'b00, do_push} - {2'b00, do_pop};
            // Overflow loses the record, never the pipeline
            if (push && full && (drops != 8'hFF)) begin
                drops <= drops + 1'b1;
            end
        end
    end

endmodule

//--- design/trace_pkg.sv
/* Trace unit package
   Shared sizes, bus addresses and the stage, record and Wishbone structs */

package trace_pkg;

    ////////////////////
    // Sizes
    ////////////////////
    localparam int ID_W       = 8;                    // Sequence id width
    localparam int WORD_W     = 16;                   // One observation word per stage
    localparam int SLOT_NUM   = 8;                    // Record slots, indexed by id mod 8
    localparam int SLOT_W     = $clog2(SLOT_NUM);
    localparam int FIFO_DEPTH = 4;                    // Retired records held for the host
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int DAT_W      = 32;                   // Wishbone data width

    // Word addresses on the bus
    localparam logic [1:0] ADR_STATUS = 2'd0;
    localparam logic [1:0] ADR_REC0   = 2'd1;
    localparam logic [1:0] ADR_REC1   = 2'd2;
    localparam logic [1:0] ADR_REC2   = 2'd3;

    ////////////////////
    // Types
    ////////////////////
    // Observation words, fetch first so the record packs in bus order
    typedef struct packed {
        logic [WORD_W-1:0] fetch;
        logic [WORD_W-1:0] decode;
        logic [WORD_W-1:0] execute;
        logic [WORD_W-1:0] memory;
        logic [WORD_W-1:0] wb;
    } stage_words_t;

    // Per-stage tracking state from the control block
    typedef struct packed {
        logic            f_valid;
        logic [ID_W-1:0] f_id;
        logic            d_valid;
        logic [ID_W-1:0] d_id;
        logic            d_stall;   // Decode holds a valid instruction this stall cycle
        logic            e_valid;
        logic [ID_W-1:0] e_id;
        logic            m_valid;
        logic [ID_W-1:0] m_id;
        logic            w_valid;
        logic [ID_W-1:0] w_id;
    } stage_ctl_t;

    // Retired record, REC0 = id/stall/fetch, REC1 = decode/execute, REC2 = memory/wb
    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [7:0]      stall_cnt;  // Saturates at 255
        stage_words_t    words;
    } trace_rec_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [1:0]       adr;
        logic [DAT_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [DAT_W-1:0] dat;
    } wb_rsp_t;

endpackage

//--- design/trace_wb_slave.sv
/* Wishbone classic slave, reads the status word and the head record
   and pops the queue on the last record word */
`timescale 1ns/1ps

module trace_wb_slave (
    input  logic                  clk,
    input  logic                  rst_n,
    input  trace_pkg::wb_req_t    wb_req,
    output trace_pkg::wb_rsp_t    wb_rsp,
    input  trace_pkg::trace_rec_t head,
    input  logic [2:0]            count,
    input  logic [7:0]            drops,
    output logic                  pop       // With the ack of a REC2 read
);
    import trace_pkg::*;

    logic             ack_q;
    logic [DAT_W-1:0] dat_q;
    logic             pop_q;
    logic             req_hit;     // New cycle accepted
    logic             not_empty;
    logic [DAT_W-1:0] status_word;
    logic [DAT_W-1:0] rd_word;

    // No new accept in the ack cycle, so ack is a single pulse
    assign req_hit   = wb_req.cyc && wb_req.stb && !ack_q;
    assign not_empty = (count != 3'd0);

    // drops 23:16, not-empty 8, count 2:0
    assign status_word = {8'h00, drops, 7'h00, not_empty, 5'h00, count};

    ////////////////////
    // Read mux
    ////////////////////
    always_comb begin
        case (wb_req.adr)
            ADR_STATUS: rd_word = status_word;
            ADR_REC0:   rd_word = {head.id, head.stall_cnt, head.words.fetch};
            ADR_REC1:   rd_word = {head.words.decode, head.words.execute};
            default:    rd_word = {head.words.memory, head.words.wb};  // REC2
        endcase
        if (!not_empty && (wb_req.adr != ADR_STATUS)) begin
            rd_word = '0;                   // Empty queue reads as zero
        end
    end

    ////////////////////
    // Response
    ////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
            pop_q <= 1'b0;
        end else begin
            ack_q <= req_hit;
            pop_q <= req_hit && !wb_req.we && (wb_req.adr == ADR_REC2) && not_empty;
        end
    end

    // Data lands with ack, writes return zero and change nothing
    always_ff @(posedge clk) begin
        if (req_hit) dat_q <= wb_req.we ? '0 : rd_word;
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;
    assign pop        = pop_q;

endmodule

//--- verif/tb_pipe_trace.sv
/* Pipeline trace testbench, plays the CPU from a stimulus file
   and reads the retired records back over Wishbone */
`timescale 1ns/1ps

module tb_pipe_trace;
    import trace_pkg::*;

    localparam int TIMEOUT    = 200;    // Cycles per bus wait
    localparam int RST_CYCLES = 3;

    logic         clk, rst_n, stall, hlt;
    stage_words_t obs;
    wb_req_t      wb_req;
    wb_rsp_t      wb_rsp;
    int           error_cnt, check_cnt;
    int           timeouts, load_errs;
    logic [81:0]  stim_q [$];           // {stall, hlt, words} per cycle

    pipe_trace_top u_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .obs    (obs),
        .stall  (stall),
        .hlt    (hlt),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    trace_checker u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .error_cnt (error_cnt),
        .check_cnt (check_cnt)
    );

    bind trace_wb_slave trace_properties u_props (
        .clk(clk), .rst_n(rst_n), .wb_req(wb_req), .wb_rsp(wb_rsp), .pop(pop)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // Stimulus file
    ////////////////////
    task automatic load_input();
        int                fd, n;
        string             line;
        logic [31:0]       a, b;
        logic [WORD_W-1:0] w0, w1, w2, w3, w4;
        fd = $fopen("verif/trace_input.txt", "r");
        if (fd == 0) begin
            load_errs++;
            $display("Cannot open the stimulus file verif/trace_input.txt");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = 7;
            case (line[0])
                "S": begin
                    n = $sscanf(line, "S %h %h %h %h %h %h %h", a, b, w0, w1, w2, w3, w4);
                    stim_q.push_back({a[0], b[0], w0, w1, w2, w3, w4});
                end
                "R": begin
                    n = $sscanf(line, "R %h %h %h %h %h %h %h", a, b, w0, w1, w2, w3, w4);
                    u_chk.add_rec({a[7:0], b[7:0], w0, w1, w2, w3, w4});
                end
                "D": if ($sscanf(line, "D %h", a) == 1) u_chk.set_drops(a[7:0]);
                default: ;                      // Comments and blank lines
            endcase
            if (n != 7) begin
                load_errs++;
                $display("Malformed stimulus line: %s", line);
            end
        end
        $fclose(fd);
    endtask

    // Inputs change 1 ns after the edge
    task automatic drive_cycle(input logic [81:0] s);
        @(posedge clk);
        #1 {stall, hlt, obs} = s;
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        rdat = '0;
        if (timeouts == 0) begin
            @(posedge clk);
            #1 wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
            n = 0;
            do begin
                @(posedge clk);
                #1 n++;
            end while (!wb_rsp.ack && n < TIMEOUT);
            if (wb_rsp.ack) rdat = wb_rsp.dat;
            else begin
                timeouts++;
                $display("Timed out waiting for ack on bus address %0d", adr);
            end
            wb_req = '0;
        end
    endtask

    task automatic finish_run();
        int asrt;
        asrt = u_dut.u_wb.u_props.fail_cnt;
        $display("Checks %0d, errors %0d, assertion failures %0d, timeouts %0d, input errors %0d",
                 check_cnt, error_cnt, asrt, timeouts, load_errs);
        if (error_cnt + asrt + timeouts + load_errs == 0) $display("** PASS **");
        else $display("** FAIL **");
        $finish;
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        logic [31:0] status, rd;
        int          recs;
        rst_n     = 1'b0;
        stall     = 1'b0;
        hlt       = 1'b0;
        obs       = '0;
        wb_req    = '0;
        timeouts  = 0;
        load_errs = 0;
        load_input();
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
        foreach (stim_q[i]) drive_cycle(stim_q[i]);
        drive_cycle('0);                        // CPU side goes idle
        // Writes to the full queue are acked and leave the status alone
        wb_access(1'b0, ADR_STATUS, '0, status);
        wb_access(1'b1, ADR_STATUS, 32'h00ff_00ff, rd);
        wb_access(1'b1, ADR_REC2, 32'hffff_ffff, rd);
        // Drain the queue while the not-empty flag is set
        wb_access(1'b0, ADR_STATUS, '0, status);
        recs = 0;
        while (status[8] && timeouts == 0 && recs < 2 * FIFO_DEPTH) begin
            wb_access(1'b0, ADR_REC0, '0, rd);
            wb_access(1'b0, ADR_REC1, '0, rd);
            wb_access(1'b0, ADR_REC2, '0, rd);
            wb_access(1'b0, ADR_STATUS, '0, status);
            recs++;
        end
        // Empty queue reads zero
        wb_access(1'b0, ADR_REC0, '0, rd);
        wb_access(1'b0, ADR_REC1, '0, rd);
        wb_access(1'b0, ADR_REC2, '0, rd);
        wb_access(1'b0, ADR_STATUS, '0, status);
        u_chk.check_done();
        finish_run();
    end

endmodule

//--- verif/trace_checker.sv
/* Trace checker, rebuilds records from the bus reads and compares
   them and every status word with the expected values */
`timescale 1ns/1ps

module trace_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  trace_pkg::wb_req_t wb_req,
    input  trace_pkg::wb_rsp_t wb_rsp,
    output int                 error_cnt,
    output int                 check_cnt
);
    import trace_pkg::*;

    trace_rec_t       exp_q [$];        // Records still to be read, oldest first
    logic [7:0]       exp_drops;
    logic [1:0]       req_adr;          // Access waiting for its ack
    logic             req_we;
    logic [DAT_W-1:0] rec0_q, rec1_q;   // First two words of the record in flight

    initial begin
        error_cnt = 0;
        check_cnt = 0;
        exp_drops = '0;
        req_adr   = '0;
        req_we    = 1'b0;
    end

    task automatic add_rec(input trace_rec_t rec);
        exp_q.push_back(rec);
    endtask

    task automatic set_drops(input logic [7:0] d);
        exp_drops = d;
    endtask

    task automatic compare(input string what, input logic [95:0] got, input logic [95:0] exp);
        check_cnt++;
        if (got !== exp) begin
            error_cnt++;
            $display("[FAIL] t=%0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    // Status the host should see: drops 23:16, not-empty 8, count 2:0
    function automatic logic [31:0] exp_status();
        logic [2:0] cnt;
        cnt = 3'(exp_q.size());
        return {8'h00, exp_drops, 7'h00, (cnt != 3'd0), 5'h00, cnt};
    endfunction

    task automatic check_read(input logic [1:0] adr, input logic [31:0] dat);
        trace_rec_t got;
        if (adr == ADR_STATUS) compare("status word", 96'(dat), 96'(exp_status()));
        else if (exp_q.size() == 0) compare("empty queue read", 96'(dat), '0);
        else if (adr == ADR_REC0) rec0_q = dat;
        else if (adr == ADR_REC1) rec1_q = dat;
        else begin
            got = {rec0_q, rec1_q, dat};                // REC2 completes the record
            compare($sformatf("record %0d", exp_q[0].id), got, exp_q[0]);
            void'(exp_q.pop_front());
        end
    endtask

    // Reads only, write acks carry nothing to check
    always @(posedge clk) begin
        if (rst_n && wb_rsp.ack && !req_we) check_read(req_adr, wb_rsp.dat);
        if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
            req_adr <= wb_req.adr;
            req_we  <= wb_req.we;
        end
    end

    task automatic check_done();
        if (exp_q.size() != 0) begin
            error_cnt++;
            $display("%0d expected records were never read from the queue", exp_q.size());
        end
    endtask

endmodule

//--- verif/trace_input.txt
# S stall hlt fetch decode execute memory wb, hex, one line per cycle after reset
# R id stall_cnt fetch decode execute memory wb, expected records in order; D expected drops
S 0 0 1000 2000 3000 4000 5000
S 0 0 1001 2001 3001 4001 5001
S 1 0 1002 2002 3002 4002 5002
S 1 0 1003 2003 3003 4003 5003
S 0 0 1004 2004 3004 4004 5004
S 0 0 1005 2005 3005 4005 5005
S 0 0 1006 2006 3006 4006 5006
S 0 1 1007 2007 3007 4007 5007
S 0 0 1008 2008 3008 4008 5008
S 0 0 1009 2009 3009 4009 5009
S 0 0 100a 200a 300a 400a 500a
S 0 0 100b 200b 300b 400b 500b
S 0 0 100c 200c 300c 400c 500c
S 0 0 100d 200d 300d 400d 500d
S 0 0 100e 200e 300e 400e 500e
S 0 0 100f 200f 300f 400f 500f
# Ids 0 to 5 retire, 4 and 5 arrive with the queue full
R 00 00 1000 2001 3002 4003 5004
R 01 02 1001 2004 3005 4006 5007
R 02 00 1004 2005 3006 4007 5008
R 03 00 1005 2006 3007 4008 5009
D 02

//--- verif/trace_properties.sv
/* Bus timing properties, bound into the Wishbone slave */
`timescale 1ns/1ps

module trace_properties (
    input logic               clk,
    input logic               rst_n,
    input trace_pkg::wb_req_t wb_req,
    input trace_pkg::wb_rsp_t wb_rsp,
    input logic               pop
);
    import trace_pkg::*;

    int fail_cnt = 0;   // Read by the testbench top at the end of the run

    // Classic cycle, ack is a single pulse
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            fail_cnt++;
            $error("ack stayed high for two cycles");
        end

    ack_follows: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_req.cyc && wb_req.stb && !wb_rsp.ack) |=> wb_rsp.ack)
        else begin
            fail_cnt++;
            $error("no ack one cycle after strobe");
        end

    // Head leaves the queue only on an acknowledged REC2 read
    pop_on_rec2: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (wb_rsp.ack && !$past(wb_req.we) && ($past(wb_req.adr) == ADR_REC2)))
        else begin
            fail_cnt++;
            $error("pop without an acknowledged REC2 read");
        end

endmodule

//--- verilog.f
design/trace_pkg.sv
design/trace_ctrl.sv
design/trace_capture.sv
design/trace_fifo.sv
design/trace_wb_slave.sv
design/pipe_trace_top.sv
verif/trace_properties.sv
verif/trace_checker.sv
verif/tb_pipe_trace.sv
